/* frv_decode.f */
+incdir+.
frv_pkg.sv
frv_decode_match.sv
frv_decode_uop.sv
frv_decode_imm.sv
frv_decode_operands.sv
frv_decode.sv
frv_decode_props.sv
frv_decode_tb.sv

/* frv_decode.sv */
// Decode stage top: sub-decoders, trap detection and the output register
`timescale 1ns/1ns
`include "frv_defines.svh"

module frv_decode (
    input  logic                 g_clk,
    input  logic                 rst,
    input  logic                 d_valid,   // Word present this cycle
    input  logic [`FRV_XLEN-1:0] d_data,
    input  logic                 d_error,   // Fetch error on d_data
    output frv_pkg::decoded_t    p
);
    import frv_pkg::*;

    instr_e                instr;
    fu_e                   fu;
    logic [`FRV_UOP_W-1:0] uop;
    logic [`FRV_XLEN-1:0]  imm;
    logic [`FRV_REG_W-1:0] rs1;
    logic [`FRV_REG_W-1:0] rs2;
    logic [`FRV_REG_W-1:0] rd;
    opr_src_t              opr_src;
    logic                  illegal;
    logic                  trap;
    decoded_t              p_next;

    // --------------------------------------------------
    // Combinational decoders

    frv_decode_match u_match (
        .d_data (d_data),
        .instr  (instr)
    );

    frv_decode_uop u_uop (
        .instr (instr),
        .fu    (fu),
        .uop   (uop)
    );

    frv_decode_imm u_imm (
        .d_data (d_data),
        .instr  (instr),
        .imm    (imm)
    );

    frv_decode_operands u_operands (
        .d_data  (d_data),
        .instr   (instr),
        .rs1     (rs1),
        .rs2     (rs2),
        .rd      (rd),
        .opr_src (opr_src)
    );

    // --------------------------------------------------
    // Trap catching, illegal opcode wins over fetch error
    assign illegal = instr == INSTR_ILLEGAL;
    assign trap    = d_valid && (d_error || illegal);

    always_comb begin
        p_next.valid   = d_valid;
        p_next.trap    = trap;
        p_next.rd      = !trap   ? rd                :
                         illegal ? `FRV_TRAP_IOPCODE :
                                   `FRV_TRAP_IACCESS;
        p_next.rs1     = rs1;
        p_next.rs2     = rs2;
        p_next.imm     = imm;
        p_next.fu      = fu;
        p_next.uop     = uop;
        p_next.opr_src = opr_src;
        p_next.instr   = d_data;
    end

    // One-cycle pipeline register, only valid and trap are cleared
    always_ff @(posedge g_clk) begin
        p <= p_next;
        if (rst) begin
            p.valid <= 1'b0;
            p.trap  <= 1'b0;
        end
    end

endmodule

/* frv_decode_imm.sv */
// Immediate extraction for the RV32 formats and per-instruction selection
`timescale 1ns/1ns
`include "frv_defines.svh"

module frv_decode_imm (
    input  logic [`FRV_XLEN-1:0] d_data,
    input  frv_pkg::instr_e      instr,
    output logic [`FRV_XLEN-1:0] imm
);
    import frv_pkg::*;

    logic [`FRV_XLEN-1:0] imm_i;
    logic [`FRV_XLEN-1:0] imm_s;
    logic [`FRV_XLEN-1:0] imm_b;
    logic [`FRV_XLEN-1:0] imm_u;
    logic [`FRV_XLEN-1:0] imm_j;
    logic [`FRV_XLEN-1:0] imm_sh;

    // --------------------------------------------------
    // Format decode, all sign-extended from bit 31
    assign imm_i = {{20{d_data[31]}}, d_data[31:20]};
    assign imm_s = {{20{d_data[31]}}, d_data[31:25], d_data[11:7]};
    assign imm_b = {{20{d_data[31]}}, d_data[7], d_data[30:25], d_data[11:8], 1'b0};
    assign imm_u = {d_data[31:12], 12'b0};
    assign imm_j = {{12{d_data[31]}}, d_data[19:12], d_data[20], d_data[30:21], 1'b0};

    assign imm_sh = {27'b0, d_data[24:20]};  // Shift amount, no sign

    // --------------------------------------------------
    always_comb begin
        case (instr)
            INSTR_ADDI, INSTR_SLTI, INSTR_SLTIU,
            INSTR_XORI, INSTR_ORI, INSTR_ANDI,
            INSTR_LB, INSTR_LH, INSTR_LW, INSTR_LBU, INSTR_LHU,
            INSTR_JALR:
                imm = imm_i;
            INSTR_SB, INSTR_SH, INSTR_SW:
                imm = imm_s;
            INSTR_BEQ, INSTR_BNE, INSTR_BLT,
            INSTR_BGE, INSTR_BLTU, INSTR_BGEU:
                imm = imm_b;
            INSTR_JAL:
                imm = imm_j;
            INSTR_LUI, INSTR_AUIPC:
                imm = imm_u;
            INSTR_SLLI, INSTR_SRLI, INSTR_SRAI:
                imm = imm_sh;
            default:
                imm = '0;   // Register-register, system, illegal
        endcase
    end

endmodule

/* frv_decode_match.sv */
// Instruction recogniser for RV32IM words, illegal words flagged
`timescale 1ns/1ns
`include "frv_defines.svh"

module frv_decode_match (
    input  logic [`FRV_XLEN-1:0] d_data,
    output frv_pkg::instr_e      instr
);
    import frv_pkg::*;

    // Whole system words, rs1 and rd must be x0
    localparam logic [31:0] WORD_ECALL =
        {`FRV_F12_ECALL, `FRV_REG_ZERO, 3'b000, `FRV_REG_ZERO, OPC_SYSTEM};
    localparam logic [31:0] WORD_EBREAK =
        {`FRV_F12_EBREAK, `FRV_REG_ZERO, 3'b000, `FRV_REG_ZERO, OPC_SYSTEM};
    localparam logic [31:0] WORD_MRET =
        {`FRV_F12_MRET, `FRV_REG_ZERO, 3'b000, `FRV_REG_ZERO, OPC_SYSTEM};

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcode_e'(d_data[6:0]);   // Low bits other than 2'b11 never match
    assign funct3 = d_data[14:12];
    assign funct7 = d_data[31:25];

    always_comb begin
        instr = INSTR_ILLEGAL;
        case (opcode)
            OPC_LUI:    instr = INSTR_LUI;
            OPC_AUIPC:  instr = INSTR_AUIPC;
            OPC_JAL:    instr = INSTR_JAL;
            OPC_JALR:   if (funct3 == 3'b000) instr = INSTR_JALR;
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  instr = INSTR_BEQ;
                    3'b001:  instr = INSTR_BNE;
                    3'b100:  instr = INSTR_BLT;
                    3'b101:  instr = INSTR_BGE;
                    3'b110:  instr = INSTR_BLTU;
                    3'b111:  instr = INSTR_BGEU;
                    default: instr = INSTR_ILLEGAL;
                endcase
            end
            OPC_LOAD: begin
                case (funct3)
                    3'b000:  instr = INSTR_LB;
                    3'b001:  instr = INSTR_LH;
                    3'b010:  instr = INSTR_LW;
                    3'b100:  instr = INSTR_LBU;
                    3'b101:  instr = INSTR_LHU;
                    default: instr = INSTR_ILLEGAL;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    3'b000:  instr = INSTR_SB;
                    3'b001:  instr = INSTR_SH;
                    3'b010:  instr = INSTR_SW;
                    default: instr = INSTR_ILLEGAL;
                endcase
            end
            OPC_OP_IMM: begin
                case (funct3)
                    3'b000:  instr = INSTR_ADDI;
                    3'b010:  instr = INSTR_SLTI;
                    3'b011:  instr = INSTR_SLTIU;
                    3'b100:  instr = INSTR_XORI;
                    3'b110:  instr = INSTR_ORI;
                    3'b111:  instr = INSTR_ANDI;
                    3'b001:  if (funct7 == `FRV_F7_BASE) instr = INSTR_SLLI;
                    default: begin                         // funct3 101, shift right
                        if (funct7 == `FRV_F7_BASE) instr = INSTR_SRLI;
                        else if (funct7 == `FRV_F7_ALT) instr = INSTR_SRAI;
                    end
                endcase
            end
            OPC_OP: begin
                if (funct7 == `FRV_F7_BASE) begin
                    case (funct3)
                        3'b000:  instr = INSTR_ADD;
                        3'b001:  instr = INSTR_SLL;
                        3'b010:  instr = INSTR_SLT;
                        3'b011:  instr = INSTR_SLTU;
                        3'b100:  instr = INSTR_XOR;
                        3'b101:  instr = INSTR_SRL;
                        3'b110:  instr = INSTR_OR;
                        default: instr = INSTR_AND;
                    endcase
                end else if (funct7 == `FRV_F7_ALT) begin
                    if (funct3 == 3'b000) instr = INSTR_SUB;
                    else if (funct3 == 3'b101) instr = INSTR_SRA;
                end else if (funct7 == `FRV_F7_MULDIV) begin
                    instr = instr_e'(INSTR_MUL + 6'(funct3));   // MUL..REMU in funct3 order
                end
            end
            OPC_SYSTEM: begin
                if (d_data == WORD_ECALL) instr = INSTR_ECALL;
                else if (d_data == WORD_EBREAK) instr = INSTR_EBREAK;
                else if (d_data == WORD_MRET) instr = INSTR_MRET;
            end
            default: instr = INSTR_ILLEGAL;  // FENCE, FENCE.I, CSR and the rest
        endcase
    end

endmodule

/* frv_decode_operands.sv */
// Register address extraction and operand source flags for dispatch
`timescale 1ns/1ns
`include "frv_defines.svh"

module frv_decode_operands (
    input  logic [`FRV_XLEN-1:0]  d_data,
    input  frv_pkg::instr_e       instr,
    output logic [`FRV_REG_W-1:0] rs1,
    output logic [`FRV_REG_W-1:0] rs2,
    output logic [`FRV_REG_W-1:0] rd,
    output frv_pkg::opr_src_t     opr_src
);
    import frv_pkg::*;

    logic is_alu_rr;
    logic is_alu_ri;
    logic is_muldiv;
    logic is_branch;
    logic is_load;
    logic is_store;

    // Fixed fields of the 32-bit formats
    assign rs1 = d_data[19:15];
    assign rs2 = d_data[24:20];
    assign rd  = d_data[11:7];

    // --------------------------------------------------
    // Instruction classes
    assign is_alu_rr = instr inside {[INSTR_ADD:INSTR_AND]};
    assign is_alu_ri = instr inside {[INSTR_ADDI:INSTR_SRAI]};
    assign is_muldiv = instr inside {[INSTR_MUL:INSTR_REMU]};
    assign is_branch = instr inside {[INSTR_BEQ:INSTR_BGEU]};
    assign is_load   = instr inside {[INSTR_LB:INSTR_LHU]};
    assign is_store  = instr inside {[INSTR_SB:INSTR_SW]};

    // --------------------------------------------------
    // Everything reads rs1 except these
    assign opr_src.opra_rs1  = !(instr inside {INSTR_ILLEGAL, INSTR_LUI, INSTR_AUIPC,
                                               INSTR_JAL, INSTR_ECALL, INSTR_EBREAK,
                                               INSTR_MRET});
    assign opr_src.opra_pcim = instr == INSTR_AUIPC;

    assign opr_src.oprb_rs2  = is_alu_rr || is_muldiv || is_branch;
    assign opr_src.oprb_imm  = is_alu_ri || is_load || is_store
                            || instr inside {INSTR_LUI, INSTR_JALR};

    assign opr_src.oprc_rs2  = is_store;                           // Store data
    assign opr_src.oprc_pcim = is_branch || instr == INSTR_JAL;    // Jump target

endmodule

/* frv_decode_props.sv */
// Bound concurrent assertions on valid, trap and reset behaviour of the decode stage
`timescale 1ns/1ns

module frv_decode_props (
    input logic              g_clk,
    input logic              rst,
    input logic              d_valid,
    input frv_pkg::decoded_t p
);

    // Output valid is the input valid one cycle later
    a_valid_follows: assert property (@(posedge g_clk) disable iff (rst)
        d_valid |=> p.valid)
        else $error("p.valid not set one cycle after a valid input");

    a_idle_follows: assert property (@(posedge g_clk) disable iff (rst)
        !d_valid |=> !p.valid && !p.trap)
        else $error("p.valid or p.trap set one cycle after an idle input");

    a_reset_clears: assert property (@(posedge g_clk)
        rst |=> !p.valid && !p.trap)
        else $error("p.valid or p.trap still set after a reset cycle");

endmodule

bind frv_decode frv_decode_props u_props (
    .g_clk   (g_clk),
    .rst     (rst),
    .d_valid (d_valid),
    .p       (p)
);

/* frv_decode_tb.sv */
// Decode stage testbench: clock, reset, random words, reference model, checks, watchdog
`timescale 1ns/1ns
`include "frv_defines.svh"

module frv_decode_tb;
    import frv_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int STIM_DELAY   = 2;    // Drive point after the rising edge
    localparam int RESET_CYCLES = 8;
    localparam int N_ITEMS      = 3000;
    localparam int TIMEOUT_NS   = (N_ITEMS + RESET_CYCLES + 50) * CLK_PERIOD;

    logic                 g_clk;
    logic                 rst;
    logic                 d_valid;
    logic [`FRV_XLEN-1:0] d_data;
    logic                 d_error;
    decoded_t             p;

    decoded_t expect_q[$];  // One entry per driven cycle

    frv_decode UUT (
        .g_clk   (g_clk),
        .rst     (rst),
        .d_valid (d_valid),
        .d_data  (d_data),
        .d_error (d_error),
        .p       (p)
    );

    initial begin
        g_clk = 1'b0;
        forever #(CLK_PERIOD / 2) g_clk = ~g_clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns before all items were checked", TIMEOUT_NS);
        $display("TEST FAILED");
        $fatal(1, "Simulation hung");
    end

    // --------------------------------------------------
    // Error reporting and compare tasks

    task automatic report_error(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    task automatic check_fu(input fu_e got, input fu_e exp, input logic [31:0] word);
        if (got !== exp)
            report_error($sformatf("word %h fu got %b expected %b", word, got, exp));
    endtask

    task automatic check_opr(input opr_src_t got, input opr_src_t exp, input logic [31:0] word);
        if (got !== exp)
            report_error($sformatf("word %h opr_src got %b expected %b", word, got, exp));
    endtask

    task automatic check_decoded(input decoded_t got, input decoded_t exp);
        if (got.valid !== exp.valid || got.trap !== exp.trap)
            report_error($sformatf("word %h valid,trap got %b%b expected %b%b",
                                   exp.instr, got.valid, got.trap, exp.valid, exp.trap));
        if (exp.valid) begin    // Remaining fields are don't-care when idle
            check_fu(got.fu, exp.fu, exp.instr);
            check_opr(got.opr_src, exp.opr_src, exp.instr);
            if (got.rd !== exp.rd)
                report_error($sformatf("word %h rd got %0d expected %0d",
                                       exp.instr, got.rd, exp.rd));
            if (got.rs1 !== exp.rs1 || got.rs2 !== exp.rs2)
                report_error($sformatf("word %h rs1,rs2 got %0d,%0d expected %0d,%0d",
                                       exp.instr, got.rs1, got.rs2, exp.rs1, exp.rs2));
            if (got.imm !== exp.imm)
                report_error($sformatf("word %h imm got %h expected %h",
                                       exp.instr, got.imm, exp.imm));
            if (got.uop !== exp.uop)
                report_error($sformatf("word %h uop got %b expected %b",
                                       exp.instr, got.uop, exp.uop));
            if (got.instr !== exp.instr)
                report_error($sformatf("instr got %h expected %h", got.instr, exp.instr));
        end
    endtask

    // --------------------------------------------------
    // Reference model

    function automatic alu_op_e alu_by_f3(input logic [2:0] f3);
        case (f3)
            3'd0:    return ALU_ADD;
            3'd1:    return ALU_SLL;
            3'd2:    return ALU_SLT;
            3'd3:    return ALU_SLTU;
            3'd4:    return ALU_XOR;
            3'd5:    return ALU_SRL;
            3'd6:    return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic mul_op_e mul_by_f3(input logic [2:0] f3);
        case (f3)
            3'd0:    return MUL_MUL;
            3'd1:    return MUL_MULH;
            3'd2:    return MUL_MULHSU;
            3'd3:    return MUL_MULHU;
            3'd4:    return MUL_DIV;
            3'd5:    return MUL_DIVU;
            3'd6:    return MUL_REM;
            default: return MUL_REMU;
        endcase
    endfunction

    function automatic cfu_op_e branch_by_f3(input logic [2:0] f3);
        case (f3)
            3'd0:    return CFU_BEQ;
            3'd1:    return CFU_BNE;
            3'd4:    return CFU_BLT;
            3'd5:    return CFU_BGE;
            3'd6:    return CFU_BLTU;
            default: return CFU_BGEU;
        endcase
    endfunction

    function automatic decoded_t model_decode(input logic valid, input logic [31:0] w,
                                              input logic err);
        decoded_t   d;
        lsu_uop_t   lsu;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       legal;
        f3    = w[14:12];
        f7    = w[31:25];
        d     = '0;
        lsu   = '0;
        legal = 1'b1;
        d.fu  = FU_ALU;
        case (w[6:0])
            OPC_LUI: begin
                d.uop = ALU_OR;
                d.imm = {w[31:12], 12'b0};
                d.opr_src.oprb_imm = 1'b1;
            end
            OPC_AUIPC: begin
                d.uop = ALU_ADD;
                d.imm = {w[31:12], 12'b0};
                d.opr_src.opra_pcim = 1'b1;
            end
            OPC_JAL: begin
                d.fu  = FU_CFU;
                d.uop = CFU_JALI;
                d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                d.opr_src.oprc_pcim = 1'b1;
            end
            OPC_JALR: begin
                legal = f3 == 3'b000;
                d.fu  = FU_CFU;
                d.uop = CFU_JALR;
                d.imm = {{20{w[31]}}, w[31:20]};
                d.opr_src.opra_rs1 = 1'b1;
                d.opr_src.oprb_imm = 1'b1;
            end
            OPC_BRANCH: begin
                legal = !(f3 inside {3'd2, 3'd3});
                d.fu  = FU_CFU;
                d.uop = branch_by_f3(f3);
                d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                d.opr_src = '{opra_rs1: 1'b1, oprb_rs2: 1'b1, oprc_pcim: 1'b1, default: 1'b0};
            end
            OPC_LOAD, OPC_STORE: begin
                lsu.load  = w[5] == 1'b0;
                lsu.store = w[5] == 1'b1;
                lsu.width = f3[1:0] == 2'd0 ? LSU_BYTE : f3[1:0] == 2'd1 ? LSU_HALF : LSU_WORD;
                lsu.sign  = lsu.load && (f3 inside {3'd0, 3'd1});   // LB and LH only
                legal = lsu.load ? f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}
                                 : f3 inside {3'd0, 3'd1, 3'd2};
                d.fu  = FU_LSU;
                d.uop = lsu;
                d.imm = lsu.load ? {{20{w[31]}}, w[31:20]}
                                 : {{20{w[31]}}, w[31:25], w[11:7]};
                d.opr_src = '{opra_rs1: 1'b1, oprb_imm: 1'b1, oprc_rs2: lsu.store,
                              default: 1'b0};
            end
            OPC_OP_IMM: begin
                d.uop = alu_by_f3(f3);
                d.imm = {{20{w[31]}}, w[31:20]};
                if (f3 == 3'd1 || f3 == 3'd5) begin    // Shift by immediate
                    d.imm = {27'b0, w[24:20]};
                    legal = f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20);
                    if (f7 == 7'h20) d.uop = ALU_SRA;
                end
                d.opr_src = '{opra_rs1: 1'b1, oprb_imm: 1'b1, default: 1'b0};
            end
            OPC_OP: begin
                d.uop = alu_by_f3(f3);
                if (f7 == 7'h01) begin
                    d.fu  = FU_MUL;
                    d.uop = mul_by_f3(f3);
                end else if (f7 == 7'h20) begin
                    legal = f3 == 3'd0 || f3 == 3'd5;
                    d.uop = f3 == 3'd0 ? ALU_SUB : ALU_SRA;
                end else begin
                    legal = f7 == 7'h00;
                end
                d.opr_src = '{opra_rs1: 1'b1, oprb_rs2: 1'b1, default: 1'b0};
            end
            OPC_SYSTEM: begin
                d.fu  = FU_CFU;
                legal = w inside {32'h00000073, 32'h00100073, 32'h30200073};
                d.uop = w[21] ? CFU_MRET : w[20] ? CFU_EBREAK : CFU_ECALL;
            end
            default: legal = 1'b0;     // FENCE, FENCE.I, CSR, compressed
        endcase
        if (!legal) begin
            d.fu      = FU_ALU;
            d.uop     = '0;
            d.imm     = '0;
            d.opr_src = '0;
        end
        d.valid = valid;
        d.trap  = valid && (err || !legal);
        d.rs1   = w[19:15];
        d.rs2   = w[24:20];
        d.rd    = !d.trap ? w[11:7] : !legal ? `FRV_TRAP_IOPCODE : `FRV_TRAP_IACCESS;
        d.instr = w;
        return d;
    endfunction

    // --------------------------------------------------
    // Stimulus

    function automatic logic [31:0] random_word();
        logic [31:0] w;
        w = $urandom;
        if ($urandom % 10 == 0) return w;      // Fully random word
        case ($urandom % 10)
            0: w[6:0] = OPC_LUI;
            1: w[6:0] = OPC_AUIPC;
            2: w[6:0] = OPC_JAL;
            3: begin
                w[6:0]   = OPC_JALR;
                w[14:12] = 3'b000;
            end
            4: w[6:0] = OPC_BRANCH;
            5: w[6:0] = OPC_LOAD;
            6: w[6:0] = OPC_STORE;
            7: begin
                w[6:0] = OPC_OP_IMM;
                if (w[13:12] == 2'b01) w[31:25] = {1'b0, w[30], 5'b0};
            end
            8: begin
                w[6:0]   = OPC_OP;
                w[31:25] = {1'b0, w[30], 4'b0, w[25] & !w[30]};  // 0x00, 0x20 or 0x01
            end
            default: begin
                case ($urandom % 3)
                    0:       w = 32'h00000073;   // ECALL
                    1:       w = 32'h00100073;   // EBREAK
                    default: w = 32'h30200073;   // MRET
                endcase
            end
        endcase
        return w;
    endfunction

    initial begin
        void'($urandom(32'h1d06));
        rst         = 1'b1;
        d_valid     = 1'b0;
        d_data      = '0;
        d_error     = 1'b0;

        // Inputs stay busy during reset so the clear is visible
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge g_clk);
            #(STIM_DELAY);
            check_decoded(p, '0);
            rst     = i != RESET_CYCLES - 1;
            d_valid = i < RESET_CYCLES - 2;   // Idle on the last reset edge
            d_data  = $urandom;
            d_error = ($urandom % 2) == 1;
        end

        for (int n = 0; n < N_ITEMS; n++) begin
            @(posedge g_clk);
            #(STIM_DELAY);
            if (expect_q.size() > 0)
                check_decoded(p, expect_q.pop_front());
            else
                check_decoded(p, '0);    // First cycle out of reset
            d_valid = ($urandom % 100) < 80;
            d_data  = random_word();
            d_error = ($urandom % 100) < 5;
            expect_q.push_back(model_decode(d_valid, d_data, d_error));
        end
        @(posedge g_clk);
        #(STIM_DELAY);
        check_decoded(p, expect_q.pop_front());

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* frv_decode_uop.sv */
// Functional unit and micro-op selection for a recognised instruction
`timescale 1ns/1ns
`include "frv_defines.svh"

module frv_decode_uop (
    input  frv_pkg::instr_e        instr,
    output frv_pkg::fu_e           fu,
    output logic [`FRV_UOP_W-1:0]  uop
);
    import frv_pkg::*;

    lsu_uop_t lsu;

    // Load/store micro-op fields
    assign lsu.load  = instr inside {INSTR_LB, INSTR_LBU, INSTR_LH, INSTR_LHU, INSTR_LW};
    assign lsu.store = instr inside {INSTR_SB, INSTR_SH, INSTR_SW};
    assign lsu.sign  = instr inside {INSTR_LB, INSTR_LH};
    assign lsu.width = instr inside {INSTR_LB, INSTR_LBU, INSTR_SB} ? LSU_BYTE :
                       instr inside {INSTR_LH, INSTR_LHU, INSTR_SH} ? LSU_HALF :
                                                                      LSU_WORD;

    // --------------------------------------------------
    // Unit select, ALU is also the illegal default
    always_comb begin
        if (instr inside {[INSTR_MUL:INSTR_REMU]})
            fu = FU_MUL;
        else if (instr inside {[INSTR_BEQ:INSTR_BGEU], INSTR_JAL, INSTR_JALR,
                               INSTR_ECALL, INSTR_EBREAK, INSTR_MRET})
            fu = FU_CFU;
        else if (lsu.load || lsu.store)
            fu = FU_LSU;
        else
            fu = FU_ALU;
    end

    // --------------------------------------------------
    always_comb begin
        case (instr)
            INSTR_ADD, INSTR_ADDI, INSTR_AUIPC: uop = ALU_ADD;  // AUIPC adds PC
            INSTR_SUB:                          uop = ALU_SUB;
            INSTR_AND, INSTR_ANDI:              uop = ALU_AND;
            INSTR_OR, INSTR_ORI, INSTR_LUI:     uop = ALU_OR;   // LUI is x0 | imm
            INSTR_XOR, INSTR_XORI:              uop = ALU_XOR;
            INSTR_SLT, INSTR_SLTI:              uop = ALU_SLT;
            INSTR_SLTU, INSTR_SLTIU:            uop = ALU_SLTU;
            INSTR_SRA, INSTR_SRAI:              uop = ALU_SRA;
            INSTR_SRL, INSTR_SRLI:              uop = ALU_SRL;
            INSTR_SLL, INSTR_SLLI:              uop = ALU_SLL;
            INSTR_BEQ:    uop = CFU_BEQ;
            INSTR_BNE:    uop = CFU_BNE;
            INSTR_BLT:    uop = CFU_BLT;
            INSTR_BGE:    uop = CFU_BGE;
            INSTR_BLTU:   uop = CFU_BLTU;
            INSTR_BGEU:   uop = CFU_BGEU;
            INSTR_JAL:    uop = CFU_JALI;
            INSTR_JALR:   uop = CFU_JALR;
            INSTR_ECALL:  uop = CFU_ECALL;
            INSTR_EBREAK: uop = CFU_EBREAK;
            INSTR_MRET:   uop = CFU_MRET;
            INSTR_MUL:    uop = MUL_MUL;
            INSTR_MULH:   uop = MUL_MULH;
            INSTR_MULHSU: uop = MUL_MULHSU;
            INSTR_MULHU:  uop = MUL_MULHU;
            INSTR_DIV:    uop = MUL_DIV;
            INSTR_DIVU:   uop = MUL_DIVU;
            INSTR_REM:    uop = MUL_REM;
            INSTR_REMU:   uop = MUL_REMU;
            INSTR_LB, INSTR_LBU, INSTR_LH, INSTR_LHU, INSTR_LW,
            INSTR_SB, INSTR_SH, INSTR_SW: uop = lsu;
            default:      uop = '0;
        endcase
    end

endmodule

/* frv_defines.svh */
// Global widths, register numbers, trap causes and fixed function codes
`ifndef FRV_DEFINES_SVH
`define FRV_DEFINES_SVH

// --------------------------------------------------
// Widths

`define FRV_XLEN  32     // Data and instruction word
`define FRV_REG_W 5      // Register address
`define FRV_UOP_W 5      // Micro-op field

// --------------------------------------------------
// Register numbers and trap causes

`define FRV_REG_ZERO     5'd0
`define FRV_TRAP_IACCESS 5'd1   // Fetch error on the word
`define FRV_TRAP_IOPCODE 5'd2   // Word is not a known instruction

// --------------------------------------------------
// Function codes

`define FRV_F7_BASE   7'b0000000
`define FRV_F7_ALT    7'b0100000  // SUB and SRA(I)
`define FRV_F7_MULDIV 7'b0000001

// funct12 of the system words
`define FRV_F12_ECALL  12'h000
`define FRV_F12_EBREAK 12'h001
`define FRV_F12_MRET   12'h302

`endif

/* frv_pkg.sv */
// Decode stage types: opcodes, instructions, units, micro-ops and decoded word
`include "frv_defines.svh"

package frv_pkg;

    // Major opcodes, low two bits included
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // One label per recognised instruction
    typedef enum logic [5:0] {
        INSTR_ILLEGAL,
        INSTR_LUI, INSTR_AUIPC, INSTR_JAL, INSTR_JALR,
        INSTR_BEQ, INSTR_BNE, INSTR_BLT, INSTR_BGE, INSTR_BLTU, INSTR_BGEU,
        INSTR_LB, INSTR_LH, INSTR_LW, INSTR_LBU, INSTR_LHU,
        INSTR_SB, INSTR_SH, INSTR_SW,
        INSTR_ADDI, INSTR_SLTI, INSTR_SLTIU, INSTR_XORI, INSTR_ORI, INSTR_ANDI,
        INSTR_SLLI, INSTR_SRLI, INSTR_SRAI,
        INSTR_ADD, INSTR_SUB, INSTR_SLL, INSTR_SLT, INSTR_SLTU,
        INSTR_XOR, INSTR_SRL, INSTR_SRA, INSTR_OR, INSTR_AND,
        INSTR_ECALL, INSTR_EBREAK, INSTR_MRET,
        INSTR_MUL, INSTR_MULH, INSTR_MULHSU, INSTR_MULHU,
        INSTR_DIV, INSTR_DIVU, INSTR_REM, INSTR_REMU
    } instr_e;

    typedef enum logic [3:0] {
        FU_ALU = 4'b0001,
        FU_MUL = 4'b0010,
        FU_CFU = 4'b0100,
        FU_LSU = 4'b1000
    } fu_e;

    typedef enum logic [4:0] {
        ALU_SLT  = 5'b00001, ALU_SLTU = 5'b00010,
        ALU_SUB  = 5'b01000, ALU_ADD  = 5'b01001,
        ALU_AND  = 5'b10001, ALU_OR   = 5'b10010, ALU_XOR = 5'b10100,
        ALU_SRL  = 5'b11001, ALU_SRA  = 5'b11010, ALU_SLL = 5'b11100
    } alu_op_e;

    typedef enum logic [4:0] {
        CFU_BEQ    = 5'b01001, CFU_BGE  = 5'b01010, CFU_BGEU = 5'b01011,
        CFU_BLT    = 5'b01100, CFU_BLTU = 5'b01101, CFU_BNE  = 5'b01110,
        CFU_EBREAK = 5'b10001, CFU_ECALL = 5'b10010, CFU_MRET = 5'b10100,
        CFU_JALR   = 5'b11000, CFU_JALI = 5'b11010
    } cfu_op_e;

    typedef enum logic [4:0] {
        MUL_MUL  = 5'b10000, MUL_MULH = 5'b10100, MUL_MULHU = 5'b10101,
        MUL_MULHSU = 5'b10111,
        MUL_DIV  = 5'b11000, MUL_DIVU = 5'b11001,
        MUL_REM  = 5'b11100, MUL_REMU = 5'b11101
    } mul_op_e;

    typedef enum logic [1:0] {
        LSU_BYTE = 2'b01,
        LSU_HALF = 2'b10,
        LSU_WORD = 2'b11
    } lsu_width_e;

    // Width lands on uop[2:1]
    typedef struct packed {
        logic       load;
        logic       store;
        lsu_width_e width;
        logic       sign;   // Sign-extend loaded data
    } lsu_uop_t;

    typedef struct packed {
        logic opra_rs1;
        logic opra_pcim;
        logic oprb_rs2;
        logic oprb_imm;
        logic oprc_rs2;
        logic oprc_pcim;
    } opr_src_t;

    typedef struct packed {
        logic                  valid;
        logic                  trap;
        logic [`FRV_REG_W-1:0] rd;     // Trap cause when trap is set
        logic [`FRV_REG_W-1:0] rs1;
        logic [`FRV_REG_W-1:0] rs2;
        logic [`FRV_XLEN-1:0]  imm;
        fu_e                   fu;
        logic [`FRV_UOP_W-1:0] uop;
        opr_src_t              opr_src;
        logic [`FRV_XLEN-1:0]  instr;
    } decoded_t;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the decode stage testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing --assert -j 0 -f frv_decode.f \
    --top-module frv_decode_tb --Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vfrv_decode_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1
